// ==== hdl/ntm_settings.svh ====
`ifndef NTM_SETTINGS_SVH
`define NTM_SETTINGS_SVH

// Q16.16 word
`define NTM_DATA_SIZE 32
`define NTM_FRAC_BITS 16

// Index and length width
`define NTM_CONTROL_SIZE 4

// Register map caps the vectors at eight words
`define NTM_MAX_LENGTH 8

// Wishbone word address width
`define NTM_WB_ADR_SIZE 7

`endif

// ==== hdl/ntm_arith_pkg.sv ====
`include "ntm_settings.svh"
`default_nettype none

package ntm_arith_pkg;

  //////////////////////////////
  // Data
  //////////////////////////////

  // Signed Q16.16
  typedef logic signed [`NTM_DATA_SIZE-1:0] fixed_t;

  //////////////////////////////
  // State machines
  //////////////////////////////

  // Shift-add multiplier
  typedef enum logic [1:0] {IDLE, RUN, DONE} mult_state_t;

  // Outer product controller, reference order
  typedef enum logic [1:0] {STARTER, INPUT_VECTOR, INPUT_SCALAR, ENDER} vmul_state_t;

endpackage

`default_nettype wire

// ==== hdl/ntm_wb_pkg.sv ====
`include "ntm_settings.svh"
`default_nettype none

package ntm_wb_pkg;

  //////////////////////////////
  // Register words
  //////////////////////////////

  typedef enum logic [`NTM_WB_ADR_SIZE-1:0] {
    CTRL   = 'd0,
    STATUS = 'd1
  } wb_reg_t;

  //////////////////////////////
  // Regions
  //////////////////////////////

  // Operand vectors
  localparam int unsigned A_BASE = 16;
  localparam int unsigned A_SPAN = 8;
  localparam int unsigned B_BASE = 24;
  localparam int unsigned B_SPAN = 8;

  // Result matrix, row-major at 8*i + j
  localparam int unsigned R_BASE = 64;
  localparam int unsigned R_SPAN = 64;

  // CTRL fields
  localparam int unsigned CTRL_START_BIT = 0;
  localparam int unsigned CTRL_LEN_LSB   = 4;
  localparam int unsigned CTRL_LEN_MSB   = 7;

  // STATUS fields
  localparam int unsigned STATUS_BUSY_BIT = 0;
  localparam int unsigned STATUS_DONE_BIT = 1;

endpackage

`default_nettype wire

// ==== hdl/scalar_fixed_multiplier.sv ====
`timescale 1ns/10ps
`include "ntm_settings.svh"
`default_nettype none

module scalar_fixed_multiplier import ntm_arith_pkg::*; (
  input  wire logic   CLK,
  input  wire logic   RST,
  input  wire logic   start,
  input  fixed_t      a,
  input  fixed_t      b,
  output logic        ready,
  output fixed_t      p
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  mult_state_t state;

  // Magnitudes and running sum
  logic [2*`NTM_DATA_SIZE-1:0]        mcand;
  logic [`NTM_DATA_SIZE-1:0]          mplier;
  logic [2*`NTM_DATA_SIZE-1:0]        acc;
  logic                               neg;
  logic [4:0]                         count;
  logic signed [2*`NTM_DATA_SIZE-1:0] product;
  logic [`NTM_DATA_SIZE-1:0]          mag_a;
  logic [`NTM_DATA_SIZE-1:0]          mag_b;

  // Two's complement of the minimum still fits as unsigned
  assign mag_a = a[`NTM_DATA_SIZE-1] ? `NTM_DATA_SIZE'(-a) : a;
  assign mag_b = b[`NTM_DATA_SIZE-1] ? `NTM_DATA_SIZE'(-b) : b;

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= IDLE;
      count <= '0;
      acc   <= '0;
      neg   <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          // Start only honoured here
          if (start) begin
            acc   <= '0;
            neg   <= a[`NTM_DATA_SIZE-1] ^ b[`NTM_DATA_SIZE-1];
            count <= '0;
            state <= RUN;
          end
        end
        RUN: begin
          if (mplier[0]) begin
            acc <= acc + mcand;
          end
          count <= count + 5'd1;
          // 32 iterations
          if (count == 5'd31) begin
            state <= DONE;
          end
        end
        // Result cycle
        DONE: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Operand shifters
  always_ff @(posedge CLK) begin
    if (state == IDLE && start) begin
      mcand  <= {{`NTM_DATA_SIZE{1'b0}}, mag_a};
      mplier <= mag_b;
    end else if (state == RUN) begin
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  //////////////////////////////
  // Result
  //////////////////////////////

  // Sign back on, then truncate to Q16.16
  assign product = neg ? -$signed(acc) : $signed(acc);
  assign p       = product[`NTM_FRAC_BITS+`NTM_DATA_SIZE-1:`NTM_FRAC_BITS];
  assign ready   = (state == DONE);

endmodule

`default_nettype wire

// ==== hdl/vector_multiplication.sv ====
`timescale 1ns/10ps
`include "ntm_settings.svh"
`default_nettype none

module vector_multiplication import ntm_arith_pkg::*; (
  input  wire logic                         CLK,
  input  wire logic                         RST,
  input  wire logic                         start,
  input  wire logic [`NTM_CONTROL_SIZE-1:0] length_in,
  input  wire logic                         vector_enable,
  input  wire logic                         scalar_enable,
  input  fixed_t                            data_in,
  output logic                              ready,
  output logic                              vector_done,
  output logic                              scalar_done,
  output fixed_t                            data_out
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  vmul_state_t state;

  // Loop indices
  logic [`NTM_CONTROL_SIZE-1:0] index_vector_loop;
  logic [`NTM_CONTROL_SIZE-1:0] index_scalar_loop;
  logic [`NTM_CONTROL_SIZE-1:0] last_index;

  // Multiplier side
  fixed_t vec_op;
  fixed_t scal_op;
  logic   mult_start;
  logic   mult_ready;
  fixed_t mult_p;

  assign last_index = length_in - `NTM_CONTROL_SIZE'd1;

  //////////////////////////////
  // Loop FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state             <= STARTER;
      index_vector_loop <= '0;
      index_scalar_loop <= '0;
      mult_start        <= 1'b0;
      ready             <= 1'b0;
      vector_done       <= 1'b0;
      scalar_done       <= 1'b0;
    end else begin
      // Strobes are single cycle
      mult_start  <= 1'b0;
      ready       <= 1'b0;
      vector_done <= 1'b0;
      scalar_done <= 1'b0;
      case (state)
        STARTER: begin
          if (start) begin
            index_vector_loop <= '0;
            index_scalar_loop <= '0;
            state             <= INPUT_VECTOR;
          end
        end
        INPUT_VECTOR: begin
          // Wait for A[i]
          if (vector_enable) begin
            state <= INPUT_SCALAR;
          end
        end
        INPUT_SCALAR: begin
          // B[j] taken, kick off the product
          if (scalar_enable) begin
            mult_start <= 1'b1;
            state      <= ENDER;
          end
        end
        ENDER: begin
          if (mult_ready) begin
            scalar_done <= 1'b1;
            if (index_vector_loop == last_index && index_scalar_loop == last_index) begin
              // Last product of the matrix
              ready <= 1'b1;
              state <= STARTER;
            end else if (index_scalar_loop == last_index) begin
              // Row finished
              vector_done       <= 1'b1;
              index_vector_loop <= index_vector_loop + `NTM_CONTROL_SIZE'd1;
              index_scalar_loop <= '0;
              state             <= INPUT_VECTOR;
            end else begin
              index_scalar_loop <= index_scalar_loop + `NTM_CONTROL_SIZE'd1;
              state             <= INPUT_SCALAR;
            end
          end
        end
        default: state <= STARTER;
      endcase
    end
  end

  // Operand and result latches
  always_ff @(posedge CLK) begin
    if (state == INPUT_VECTOR && vector_enable) begin
      vec_op <= data_in;
    end
    if (state == INPUT_SCALAR && scalar_enable) begin
      scal_op <= data_in;
    end
    if (state == ENDER && mult_ready) begin
      data_out <= mult_p;
    end
  end

  //////////////////////////////
  // Multiplier
  //////////////////////////////

  scalar_fixed_multiplier mult0 (
    .CLK  (CLK),
    .RST  (RST),
    .start(mult_start),
    .a    (vec_op),
    .b    (scal_op),
    .ready(mult_ready),
    .p    (mult_p)
  );

endmodule

`default_nettype wire

// ==== hdl/vector_sequencer.sv ====
`timescale 1ns/10ps
`include "ntm_settings.svh"
`default_nettype none

module vector_sequencer import ntm_arith_pkg::*; (
  input  wire logic                         CLK,
  input  wire logic                         RST,
  input  wire logic                         start,
  input  wire logic [`NTM_CONTROL_SIZE-1:0] length,
  output logic      [2:0]                   a_addr,
  input  fixed_t                            a_data,
  output logic      [2:0]                   b_addr,
  input  fixed_t                            b_data,
  output logic                              vector_enable,
  output logic                              scalar_enable,
  output fixed_t                            data_in,
  input  wire logic                         ready,
  input  wire logic                         vector_done,
  input  wire logic                         scalar_done,
  input  fixed_t                            data_out,
  output logic                              res_we,
  output logic      [5:0]                   res_addr,
  output fixed_t                            res_data,
  output logic                              finish
);

  //////////////////////////////
  // Counters
  //////////////////////////////

  // Row i and column j of the product in flight
  logic [2:0] row;
  logic [2:0] col;
  logic       last_col;

  assign last_col = ({1'b0, col} == length - `NTM_CONTROL_SIZE'd1);

  // Each offer is one cycle; the controller already waits in the matching state
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      row           <= '0;
      col           <= '0;
      vector_enable <= 1'b0;
      scalar_enable <= 1'b0;
      finish        <= 1'b0;
    end else begin
      vector_enable <= 1'b0;
      scalar_enable <= 1'b0;
      finish        <= 1'b0;
      if (start) begin
        // A[0] first
        row           <= '0;
        col           <= '0;
        vector_enable <= 1'b1;
      end else begin
        // Row operand taken, B[0] follows
        if (vector_enable) begin
          scalar_enable <= 1'b1;
        end
        if (scalar_done) begin
          if (last_col) begin
            col <= '0;
            row <= row + 3'd1;
          end else begin
            col <= col + 3'd1;
          end
          if (ready) begin
            finish <= 1'b1;
          end else if (vector_done) begin
            vector_enable <= 1'b1;
          end else begin
            scalar_enable <= 1'b1;
          end
        end
      end
    end
  end

  //////////////////////////////
  // Operand and result paths
  //////////////////////////////

  assign a_addr  = row;
  assign b_addr  = col;
  assign data_in = vector_enable ? a_data : b_data;

  // Counters still point at the finished product here
  assign res_we   = scalar_done;
  assign res_addr = {row, col};
  assign res_data = data_out;

endmodule

`default_nettype wire

// ==== hdl/ntm_wb_regs.sv ====
`timescale 1ns/10ps
`include "ntm_settings.svh"
`default_nettype none

module ntm_wb_regs import ntm_arith_pkg::*, ntm_wb_pkg::*; (
  input  wire logic                         CLK,
  input  wire logic                         RST,
  input  wire logic                         wb_cyc,
  input  wire logic                         wb_stb,
  input  wire logic                         wb_we,
  input  wire logic [`NTM_WB_ADR_SIZE-1:0]  wb_adr,
  input  wire logic [`NTM_DATA_SIZE-1:0]    wb_dat_w,
  output logic      [`NTM_DATA_SIZE-1:0]    wb_dat_r,
  output logic                              wb_ack,
  output logic                              start,
  output logic      [`NTM_CONTROL_SIZE-1:0] length,
  input  wire logic [2:0]                   a_addr,
  output fixed_t                            a_data,
  input  wire logic [2:0]                   b_addr,
  output fixed_t                            b_data,
  input  wire logic                         res_we,
  input  wire logic [5:0]                   res_addr,
  input  fixed_t                            res_data,
  input  wire logic                         finish
);

  //////////////////////////////
  // Storage
  //////////////////////////////

  fixed_t a_mem [`NTM_MAX_LENGTH];
  fixed_t b_mem [`NTM_MAX_LENGTH];
  fixed_t r_mem [`NTM_MAX_LENGTH*`NTM_MAX_LENGTH];
  logic   busy;
  logic   done;

  // Bus decode
  logic                         access;
  logic                         wr;
  logic                         in_a;
  logic                         in_b;
  logic                         in_r;
  logic [`NTM_CONTROL_SIZE-1:0] wr_len;
  logic                         start_ok;
  logic [`NTM_DATA_SIZE-1:0]    rd_data;

  // First cycle of stb only
  assign access = wb_cyc & wb_stb & ~wb_ack;
  assign wr     = access & wb_we;
  assign in_a   = (wb_adr >= A_BASE) && (wb_adr < A_BASE + A_SPAN);
  assign in_b   = (wb_adr >= B_BASE) && (wb_adr < B_BASE + B_SPAN);
  assign in_r   = (wb_adr >= R_BASE) && (wb_adr < R_BASE + R_SPAN);
  assign wr_len = wb_dat_w[CTRL_LEN_MSB:CTRL_LEN_LSB];

  // Idle, length 1..8
  assign start_ok = wr && (wb_adr == CTRL) && wb_dat_w[CTRL_START_BIT] && !busy &&
                    (wr_len != '0) && (wr_len <= `NTM_MAX_LENGTH);

  //////////////////////////////
  // Read mux
  //////////////////////////////

  always_comb begin
    rd_data = '0;
    if (in_a) begin
      rd_data = a_mem[wb_adr[2:0]];
    end else if (in_b) begin
      rd_data = b_mem[wb_adr[2:0]];
    end else if (in_r) begin
      rd_data = r_mem[wb_adr[5:0]];
    end else begin
      case (wb_reg_t'(wb_adr))
        // Start bit reads back as zero
        CTRL: rd_data[CTRL_LEN_MSB:CTRL_LEN_LSB] = length;
        STATUS: begin
          rd_data[STATUS_BUSY_BIT] = busy;
          rd_data[STATUS_DONE_BIT] = done;
        end
        default: rd_data = '0;
      endcase
    end
  end

  //////////////////////////////
  // Control and handshake
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wb_ack   <= 1'b0;
      wb_dat_r <= '0;
      start    <= 1'b0;
      length   <= '0;
      busy     <= 1'b0;
      done     <= 1'b0;
    end else begin
      wb_ack <= access;
      start  <= 1'b0;
      if (access && !wb_we) begin
        wb_dat_r <= rd_data;
      end
      if (finish) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
      if (start_ok) begin
        start  <= 1'b1;
        length <= wr_len;
        busy   <= 1'b1;
        done   <= 1'b0;
      end
    end
  end

  // Operands frozen while busy
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int k = 0; k < `NTM_MAX_LENGTH; k++) begin
        a_mem[k] <= '0;
        b_mem[k] <= '0;
      end
    end else if (wr && !busy) begin
      if (in_a) a_mem[wb_adr[2:0]] <= wb_dat_w;
      if (in_b) b_mem[wb_adr[2:0]] <= wb_dat_w;
    end
  end

  // Results come only from the sequencer
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int k = 0; k < `NTM_MAX_LENGTH*`NTM_MAX_LENGTH; k++) begin
        r_mem[k] <= '0;
      end
    end else if (res_we) begin
      r_mem[res_addr] <= res_data;
    end
  end

  assign a_data = a_mem[a_addr];
  assign b_data = b_mem[b_addr];

endmodule

`default_nettype wire

// ==== hdl/ntm_outer_product_top.sv ====
`timescale 1ns/10ps
`include "ntm_settings.svh"
`default_nettype none

module ntm_outer_product_top import ntm_arith_pkg::*; (
  input  wire logic                        CLK,
  input  wire logic                        RST,
  input  wire logic                        wb_cyc,
  input  wire logic                        wb_stb,
  input  wire logic                        wb_we,
  input  wire logic [`NTM_WB_ADR_SIZE-1:0] wb_adr,
  input  wire logic [`NTM_DATA_SIZE-1:0]   wb_dat_w,
  output logic      [`NTM_DATA_SIZE-1:0]   wb_dat_r,
  output logic                             wb_ack
);

  //////////////////////////////
  // Wires
  //////////////////////////////

  // Register block to sequencer
  logic                         start;
  logic [`NTM_CONTROL_SIZE-1:0] length;
  logic [2:0]                   a_addr;
  logic [2:0]                   b_addr;
  fixed_t                       a_data;
  fixed_t                       b_data;
  logic                         res_we;
  logic [5:0]                   res_addr;
  fixed_t                       res_data;
  logic                         finish;

  // Sequencer to controller stream
  logic   vector_enable;
  logic   scalar_enable;
  fixed_t data_in;
  logic   ready;
  logic   vector_done;
  logic   scalar_done;
  fixed_t data_out;

  ntm_wb_regs dut_regs (
    .CLK     (CLK),
    .RST     (RST),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_we   (wb_we),
    .wb_adr  (wb_adr),
    .wb_dat_w(wb_dat_w),
    .wb_dat_r(wb_dat_r),
    .wb_ack  (wb_ack),
    .start   (start),
    .length  (length),
    .a_addr  (a_addr),
    .a_data  (a_data),
    .b_addr  (b_addr),
    .b_data  (b_data),
    .res_we  (res_we),
    .res_addr(res_addr),
    .res_data(res_data),
    .finish  (finish)
  );

  vector_sequencer dut_seq (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .length       (length),
    .a_addr       (a_addr),
    .a_data       (a_data),
    .b_addr       (b_addr),
    .b_data       (b_data),
    .vector_enable(vector_enable),
    .scalar_enable(scalar_enable),
    .data_in      (data_in),
    .ready        (ready),
    .vector_done  (vector_done),
    .scalar_done  (scalar_done),
    .data_out     (data_out),
    .res_we       (res_we),
    .res_addr     (res_addr),
    .res_data     (res_data),
    .finish       (finish)
  );

  vector_multiplication dut_vmul (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .length_in    (length),
    .vector_enable(vector_enable),
    .scalar_enable(scalar_enable),
    .data_in      (data_in),
    .ready        (ready),
    .vector_done  (vector_done),
    .scalar_done  (scalar_done),
    .data_out     (data_out)
  );

endmodule

`default_nettype wire

// ==== tb/ntm_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module ntm_asserts (
  input wire logic CLK,
  input wire logic RST,
  input wire logic vector_enable,
  input wire logic scalar_enable,
  input wire logic ready,
  input wire logic vector_done,
  input wire logic scalar_done
);

  //////////////////////////////
  // Stream strobes
  //////////////////////////////

  // Row end always comes with a product
  row_end_has_product: assert property (@(posedge CLK) disable iff (RST)
    vector_done |-> scalar_done)
    else $error("vector_done raised without scalar_done");

  // Final product ends the matrix, not a row
  final_product_only: assert property (@(posedge CLK) disable iff (RST)
    ready |-> (scalar_done && !vector_done))
    else $error("ready raised without scalar_done or together with vector_done");

  // One operand on data_in at a time
  single_enable: assert property (@(posedge CLK) disable iff (RST)
    !(vector_enable && scalar_enable))
    else $error("vector_enable and scalar_enable both high");

endmodule

bind vector_multiplication ntm_asserts asserts0 (
  .CLK          (CLK),
  .RST          (RST),
  .vector_enable(vector_enable),
  .scalar_enable(scalar_enable),
  .ready        (ready),
  .vector_done  (vector_done),
  .scalar_done  (scalar_done)
);

`default_nettype wire

// ==== tb/ntm_checker.sv ====
`timescale 1ns/10ps
`include "ntm_settings.svh"
`default_nettype none

module ntm_checker import ntm_wb_pkg::*; (
  input  wire logic                        CLK,
  input  wire logic                        RST,
  input  wire logic                        wb_cyc,
  input  wire logic                        wb_stb,
  input  wire logic                        wb_we,
  input  wire logic [`NTM_WB_ADR_SIZE-1:0] wb_adr,
  input  wire logic [`NTM_DATA_SIZE-1:0]   wb_dat_w,
  input  wire logic [`NTM_DATA_SIZE-1:0]   wb_dat_r,
  input  wire logic                        wb_ack,
  output int                               error_count
);

  //////////////////////////////
  // Reference model
  //////////////////////////////

  logic [31:0] a_model [8];
  logic [31:0] b_model [8];
  logic [31:0] r_model [64];
  logic [3:0]  model_len;
  logic        model_busy;
  logic        model_done;
  // Next STATUS read is the first since start
  logic        first_status;

  // Bus request as seen on the previous edge
  logic        prev_req;
  logic        prev_we;
  logic        prev_ack;
  logic [6:0]  prev_adr;
  logic [31:0] prev_dat_w;

  initial error_count = 0;

  // Full signed product, keep bits 47..16
  function automatic logic [31:0] truncated_product(input logic [31:0] a, input logic [31:0] b);
    longint full;
    full = longint'($signed(a)) * longint'($signed(b));
    return full[47:16];
  endfunction

  function automatic logic in_span(input logic [6:0] adr, input int unsigned base,
                                   input int unsigned span);
    return (adr >= base) && (adr < base + span);
  endfunction

  function automatic void report_mismatch(input logic [6:0] adr, input logic [31:0] got,
                                          input logic [31:0] want);
    $display("Error at %0d ns: address %0d read %h, expected %h", $time, adr, got, want);
    error_count++;
  endfunction

  // Accepted start, rows and columns below the length only
  function automatic void start_model(input logic [3:0] len);
    model_len    = len;
    model_busy   = 1'b1;
    model_done   = 1'b0;
    first_status = 1'b1;
    for (int i = 0; i < int'(len); i++) begin
      for (int j = 0; j < int'(len); j++) begin
        r_model[8*i + j] = truncated_product(a_model[i], b_model[j]);
      end
    end
  endfunction

  function automatic void record_write(input logic [6:0] adr, input logic [31:0] data);
    logic [3:0] len;
    len = data[CTRL_LEN_MSB:CTRL_LEN_LSB];
    if (adr == CTRL) begin
      // Idle and length 1..8, else ignored
      if (data[CTRL_START_BIT] && !model_busy && len != 4'd0 && len <= 4'd8) begin
        start_model(len);
      end
    end else if (!model_busy && in_span(adr, A_BASE, A_SPAN)) begin
      a_model[adr[2:0]] = data;
    end else if (!model_busy && in_span(adr, B_BASE, B_SPAN)) begin
      b_model[adr[2:0]] = data;
    end
  endfunction

  function automatic void check_status(input logic [31:0] data);
    logic [31:0] idle_word;
    idle_word = {30'd0, model_done, 1'b0};
    if (!model_busy) begin
      if (data !== idle_word) report_mismatch(STATUS, data, idle_word);
    end else if (data === 32'h1) begin
      first_status = 1'b0;
    end else if (data === 32'h2 && !first_status) begin
      // Engine finished
      model_busy = 1'b0;
      model_done = 1'b1;
    end else begin
      report_mismatch(STATUS, data, first_status ? 32'h1 : 32'h2);
      first_status = 1'b0;
    end
  endfunction

  function automatic void check_read(input logic [6:0] adr, input logic [31:0] data);
    logic [31:0] want;
    want = '0;
    if (adr == STATUS) begin
      check_status(data);
    end else begin
      if (in_span(adr, A_BASE, A_SPAN)) want = a_model[adr[2:0]];
      else if (in_span(adr, B_BASE, B_SPAN)) want = b_model[adr[2:0]];
      else if (in_span(adr, R_BASE, R_SPAN)) want = r_model[adr[5:0]];
      else if (adr == CTRL) want = {24'd0, model_len, 4'd0};
      // Unmapped words read zero
      if (data !== want) report_mismatch(adr, data, want);
    end
  endfunction

  //////////////////////////////
  // Bus monitor
  //////////////////////////////

  always @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int k = 0; k < 64; k++) r_model[k] = '0;
      for (int k = 0; k < 8; k++) begin
        a_model[k] = '0;
        b_model[k] = '0;
      end
      model_len    = '0;
      model_busy   = 1'b0;
      model_done   = 1'b0;
      first_status = 1'b0;
      prev_req     = 1'b0;
      prev_we      = 1'b0;
      prev_ack     = 1'b0;
      prev_adr     = '0;
      prev_dat_w   = '0;
    end else begin
      // Ack belongs to the request of the previous edge
      if (wb_ack) begin
        if (!prev_req) begin
          $display("Acknowledge at %0d ns without a pending request", $time);
          error_count++;
        end else if (prev_ack) begin
          $display("Acknowledge held high for a second cycle at %0d ns", $time);
          error_count++;
        end else if (prev_we) begin
          record_write(prev_adr, prev_dat_w);
        end else begin
          check_read(prev_adr, wb_dat_r);
        end
      end
      prev_req   = wb_cyc & wb_stb;
      prev_we    = wb_we;
      prev_ack   = wb_ack;
      prev_adr   = wb_adr;
      prev_dat_w = wb_dat_w;
    end
  end

endmodule

`default_nettype wire

// ==== tb/ntm_tb.sv ====
`timescale 1ns/10ps
`include "ntm_settings.svh"
`default_nettype none

module ntm_tb import ntm_wb_pkg::*; ();

  //////////////////////////////
  // Test table
  //////////////////////////////

  typedef enum logic [1:0] {MODE_DIRECTED, MODE_RANDOM} test_mode_t;
  typedef enum logic [1:0] {ACT_RESET_CHECK, ACT_RUN, ACT_BAD_START, ACT_BUSY_WRITE} test_act_t;

  localparam int NUM_TESTS = 9;
  localparam int TEST_LEN [NUM_TESTS] = '{0, 2, 8, 1, 3, 7, 0, 9, 4};
  localparam test_mode_t TEST_MODE [NUM_TESTS] = '{
    MODE_DIRECTED, MODE_DIRECTED, MODE_RANDOM, MODE_RANDOM, MODE_RANDOM,
    MODE_RANDOM, MODE_DIRECTED, MODE_DIRECTED, MODE_RANDOM};
  localparam test_act_t TEST_ACT [NUM_TESTS] = '{
    ACT_RESET_CHECK, ACT_RUN, ACT_RUN, ACT_RUN, ACT_RUN,
    ACT_RUN, ACT_BAD_START, ACT_BAD_START, ACT_BUSY_WRITE};

  // 1.0, -2.5 against 0.75 and -3 LSB, last one exercises truncation
  localparam logic [31:0] DIR_A [2] = '{32'h0001_0000, 32'hFFFD_8000};
  localparam logic [31:0] DIR_B [2] = '{32'h0000_C000, 32'hFFFF_FFFD};

  localparam int     POLL_LIMIT  = 64*36 + 200;
  localparam longint WATCHDOG_NS = longint'(NUM_TESTS) * (64*36 + 200) * 40 * 2;

  //////////////////////////////
  // DUT and checker
  //////////////////////////////

  logic                        CLK;
  logic                        RST;
  logic                        wb_cyc;
  logic                        wb_stb;
  logic                        wb_we;
  logic [`NTM_WB_ADR_SIZE-1:0] wb_adr;
  logic [`NTM_DATA_SIZE-1:0]   wb_dat_w;
  logic [`NTM_DATA_SIZE-1:0]   wb_dat_r;
  logic                        wb_ack;
  int                          chk_errors;
  int                          tb_errors;
  int                          failed_tests;
  int                          errs_before;
  int                          errs;

  ntm_outer_product_top dut0 (
    .CLK     (CLK),
    .RST     (RST),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_we   (wb_we),
    .wb_adr  (wb_adr),
    .wb_dat_w(wb_dat_w),
    .wb_dat_r(wb_dat_r),
    .wb_ack  (wb_ack)
  );

  ntm_checker chk0 (
    .CLK        (CLK),
    .RST        (RST),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .error_count(chk_errors)
  );

  initial CLK = 1'b0;
  always #20 CLK = ~CLK;

  //////////////////////////////
  // Bus tasks
  //////////////////////////////

  // One classic cycle, driven on the falling edge
  task automatic bus_access(input logic we, input logic [6:0] adr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int waits;
    @(negedge CLK);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    waits    = 0;
    do begin
      @(negedge CLK);
      waits++;
    end while (!wb_ack && waits < 16);
    if (!wb_ack) begin
      $display("No bus acknowledge for address %0d", adr);
      tb_errors++;
    end
    rdata  = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_write(input logic [6:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, adr, data, unused);
  endtask

  task automatic bus_read(input logic [6:0] adr, output logic [31:0] data);
    bus_access(1'b0, adr, '0, data);
  endtask

  function automatic logic [6:0] word_adr(input int unsigned base, input int k);
    return 7'(base + k);
  endfunction

  function automatic logic [31:0] control_word(input int len);
    return 32'((len << 4) | 1);
  endfunction

  // Within +-256.0
  function automatic logic [31:0] random_operand();
    return $signed($urandom) >>> 7;
  endfunction

  function automatic string action_name(input test_act_t act);
    case (act)
      ACT_RESET_CHECK: return "reset state";
      ACT_RUN:         return "outer product";
      ACT_BAD_START:   return "rejected start";
      default:         return "write while busy";
    endcase
  endfunction

  //////////////////////////////
  // Test steps
  //////////////////////////////

  task automatic load_operands(input test_mode_t mode, input int len);
    for (int k = 0; k < len; k++) begin
      if (mode == MODE_DIRECTED) begin
        bus_write(word_adr(A_BASE, k), DIR_A[k % 2]);
        bus_write(word_adr(B_BASE, k), DIR_B[k % 2]);
      end else begin
        bus_write(word_adr(A_BASE, k), random_operand());
        bus_write(word_adr(B_BASE, k), random_operand());
      end
    end
  endtask

  // Poll STATUS until done
  task automatic wait_for_done();
    logic [31:0] st;
    int          polls;
    st    = '0;
    polls = 0;
    while (!st[STATUS_DONE_BIT] && polls < POLL_LIMIT) begin
      bus_read(STATUS, st);
      polls++;
    end
    if (!st[STATUS_DONE_BIT]) begin
      $display("Engine did not report done within %0d polls", POLL_LIMIT);
      tb_errors++;
    end
  endtask

  task automatic read_operands();
    logic [31:0] data;
    for (int k = 0; k < 8; k++) begin
      bus_read(word_adr(A_BASE, k), data);
      bus_read(word_adr(B_BASE, k), data);
    end
  endtask

  task automatic read_results();
    logic [31:0] data;
    for (int k = 0; k < 64; k++) begin
      bus_read(word_adr(R_BASE, k), data);
    end
  endtask

  task automatic run_test(input test_act_t act, input test_mode_t mode, input int len);
    logic [31:0] data;
    case (act)
      ACT_RESET_CHECK: begin
        bus_read(CTRL, data);
        bus_read(STATUS, data);
        // Unmapped words
        bus_read(7'd2, data);
        bus_read(7'd40, data);
        read_operands();
        read_results();
      end
      ACT_RUN: begin
        load_operands(mode, len);
        bus_write(CTRL, control_word(len));
        wait_for_done();
        read_results();
      end
      ACT_BAD_START: begin
        bus_write(CTRL, control_word(len));
        bus_read(STATUS, data);
        bus_read(CTRL, data);
        read_results();
      end
      default: begin
        load_operands(mode, len);
        bus_write(CTRL, control_word(len));
        // Dropped by the DUT while busy
        for (int k = 0; k < len; k++) begin
          bus_write(word_adr(A_BASE, k), random_operand());
        end
        wait_for_done();
        read_operands();
        read_results();
      end
    endcase
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    void'($urandom(32'hfd07_a877));
    RST          = 1'b1;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat_w     = '0;
    tb_errors    = 0;
    failed_tests = 0;
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      errs_before = chk_errors + tb_errors;
      run_test(TEST_ACT[t], TEST_MODE[t], TEST_LEN[t]);
      // Let the checker see the last ack
      repeat (2) @(negedge CLK);
      errs = chk_errors + tb_errors - errs_before;
      if (errs != 0) failed_tests++;
      $display("Test %0d, %s, length %0d: %s, %0d errors", t, action_name(TEST_ACT[t]),
               TEST_LEN[t], (errs == 0) ? "ok" : "FAILED", errs);
    end
    $display("Summary: %0d tests, %0d failed, %0d errors", NUM_TESTS, failed_tests,
             chk_errors + tb_errors);
    if (chk_errors + tb_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Run hung, watchdog expired after %0d ns", WATCHDOG_NS);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+hdl
hdl/ntm_arith_pkg.sv
hdl/ntm_wb_pkg.sv
hdl/scalar_fixed_multiplier.sv
hdl/vector_multiplication.sv
hdl/vector_sequencer.sv
hdl/ntm_wb_regs.sv
hdl/ntm_outer_product_top.sv
tb/ntm_asserts.sv
tb/ntm_checker.sv
tb/ntm_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f flist.f --top-module ntm_tb -Mdir obj_dir -o ntm_sim

./obj_dir/ntm_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
  exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1
